/* cmp_top.f */
+incdir+include
rtl/cmp_pkg.sv
rtl/hold_slot.sv
rtl/bus_port.sv
rtl/cmp_regs.sv
rtl/cmp_limiter.sv
rtl/cmp_top.sv
sim/tb_cmp_top.sv

/* Bender.yml */
package:
  name: cmp_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cmp_pkg.sv
      - rtl/hold_slot.sv
      - rtl/bus_port.sv
      - rtl/cmp_regs.sv
      - rtl/cmp_limiter.sv
      - rtl/cmp_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_cmp_top.sv

/* sim/tb_cmp_top.sv */
// Limit comparator testbench
// Directed tests over the CPU bus with a reference model of the
// registers, limiter and history, plus a random clamp sweep

`timescale 1ns/10ps
`include "cmp_macros.svh"

module tb_cmp_top import cmp_pkg::*;;

    localparam int CLK_NS     = 10;
    localparam int RST_CYCLES = 8;
    // Rough cycle budget of each test in run order
    localparam int TEST_CYCLES = 80 + 120 + 180 + 200 + 60 + 1200;
    localparam int WATCHDOG_NS = (RST_CYCLES + TEST_CYCLES) * CLK_NS * 4;

    logic     clk;
    logic     rst;
    logic     req_valid;
    logic     req_ready;
    bus_req_t req;
    logic     resp_valid;
    logic     resp_ready;
    rd_resp_t resp;
    logic     snd_irq;
    logic     snd_ready;
    snd_cmd_t snd;

    logic [31:0] lfsr_state;
    logic        rand_ready;    // Random stalls on the response channel

    // Reference model state
    logic signed [15:0] m_bound1;
    logic signed [15:0] m_bound2;
    logic signed [15:0] m_value;
    logic        [15:0] m_hist;
    logic        [3:0]  m_ptr;

    cmp_top DUT (
        .clk, .rst,
        .req_valid, .req_ready, .req,
        .resp_valid, .resp_ready, .resp,
        .snd_irq, .snd_ready, .snd
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic logic [15:0] lane_merge(input logic [15:0] old,
                                               input logic [1:0] be,
                                               input logic [15:0] wdata);
        logic [15:0] res;
        res = old;
        if (be[1])
            res[15:8] = wdata[15:8];
        if (be[0])
            res[7:0] = wdata[7:0];
        return res;
    endfunction

    // Limiter rule on the model registers packed as {flags, clamp}
    function automatic logic [31:0] limit_model();
        logic signed [15:0] lo;
        logic signed [15:0] hi;
        lo = (m_bound1 < m_bound2) ? m_bound1 : m_bound2;
        hi = (m_bound1 < m_bound2) ? m_bound2 : m_bound1;
        if (m_value < lo)
            return {`CMP_FLAG_LOW, lo};
        else if (m_value > hi)
            return {`CMP_FLAG_HIGH, hi};
        else
            return {16'h0000, m_value};
    endfunction

    function automatic logic [15:0] model_read(input logic [3:0] addr);
        logic [31:0] lim;
        lim = limit_model();
        case (addr)
            `CMP_IDX_BOUND1: return m_bound1;
            `CMP_IDX_BOUND2: return m_bound2;
            `CMP_IDX_VALUE:  return m_value;
            `CMP_IDX_FLAGS:  return lim[31:16];
            `CMP_IDX_HIST:   return m_hist;
            `CMP_IDX_ALIAS1: return m_bound2;
            `CMP_IDX_ALIAS2: return m_value;
            `CMP_IDX_CLAMP:  return lim[15:0];
            default:         return `CMP_OPEN_BUS;
        endcase
    endfunction

    task automatic model_write(input logic [3:0] addr, input logic [1:0] be,
                               input logic [15:0] wdata);
        logic [31:0] lim;
        lim = limit_model();    // Flags of the previous contents
        case (addr)
            `CMP_IDX_BOUND1: m_bound1 = lane_merge(m_bound1, be, wdata);
            `CMP_IDX_BOUND2: m_bound2 = lane_merge(m_bound2, be, wdata);
            `CMP_IDX_VALUE: begin
                m_hist[m_ptr] = (lim[31:16] == 16'h0000);
                m_ptr         = m_ptr + 4'd1;   // Wraps at 16
                m_value       = lane_merge(m_value, be, wdata);
            end
            `CMP_IDX_HIST: begin
                m_hist = '0;
                m_ptr  = '0;
            end
            `CMP_IDX_ALIAS2: m_value = lane_merge(m_value, be, wdata);
            default: ;
        endcase
    endtask

    // ------------------------------------------------------------
    // Bus handshakes enter and leave 1 ns after a rising edge
    // ------------------------------------------------------------
    task automatic wait_accept();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = req_ready;           // Transfer on the coming edge
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [1:0] be,
                             input logic [15:0] wdata);
        req_valid = 1'b1;
        req.addr  = addr;
        req.we    = 1'b1;
        req.be    = be;
        req.wdata = wdata;
        wait_accept();
        model_write(addr, be, wdata);
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [15:0] data);
        logic got;
        got       = 1'b0;
        req_valid = 1'b1;
        req.addr  = addr;
        req.we    = 1'b0;
        req.be    = 2'b11;
        req.wdata = '0;
        wait_accept();
        while (!got) begin
            @(negedge clk);
            if (resp_valid && resp_ready) begin
                data = resp.rdata;
                got  = 1'b1;
            end
            @(posedge clk);
            #1;
            resp_ready = rand_ready ? (rand_bits(1) != 16'h0000) : 1'b1;
        end
    endtask

    task automatic read_check(input string name, input logic [3:0] addr);
        logic [15:0] data;
        bus_read(addr, data);
        check($sformatf("%s @%0d", name, addr), model_read(addr), data);
    endtask

    // Take one sound command off the channel
    task automatic receive_snd(input string name, input logic [7:0] code);
        logic got;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (snd_irq && snd_ready) begin
                check(name, code, snd.code);
                got = 1'b1;
            end
            @(posedge clk);
            #1;
        end
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic reset_decode();
        check("reset req_ready", 1'b1, req_ready);
        check("reset resp_valid", 1'b0, resp_valid);
        check("reset snd_irq", 1'b0, snd_irq);
        for (int a = 0; a < 16; a++)
            read_check("reset_decode", a[3:0]);  // 8..15 are open bus
    endtask

    task automatic byte_lanes_aliases();
        bus_write(`CMP_IDX_BOUND1, 2'b11, 16'h1234);
        bus_write(`CMP_IDX_BOUND1, 2'b10, 16'hab00);   // Upper only
        bus_write(`CMP_IDX_BOUND1, 2'b01, 16'h77cd);   // Lower only
        read_check("byte_lanes", `CMP_IDX_BOUND1);
        bus_write(`CMP_IDX_BOUND2, 2'b01, 16'hff56);
        bus_write(`CMP_IDX_BOUND2, 2'b10, 16'h9a11);
        read_check("byte_lanes", `CMP_IDX_BOUND2);
        read_check("byte_lanes", `CMP_IDX_ALIAS1);
        bus_write(`CMP_IDX_BOUND2, 2'b00, 16'h0000);   // No lanes
        read_check("byte_lanes", `CMP_IDX_ALIAS1);
        bus_write(`CMP_IDX_ALIAS2, 2'b11, 16'hc3a5);
        bus_write(`CMP_IDX_ALIAS2, 2'b10, 16'h0f00);
        read_check("byte_lanes", `CMP_IDX_VALUE);
        bus_write(`CMP_IDX_ALIAS2, 2'b01, 16'h00e1);
        read_check("byte_lanes", `CMP_IDX_ALIAS2);
        read_check("byte_lanes", `CMP_IDX_HIST);       // No bits from alias
    endtask

    task automatic clamp_case(input logic [15:0] b1, input logic [15:0] b2,
                              input logic [15:0] v);
        bus_write(`CMP_IDX_BOUND1, 2'b11, b1);
        bus_write(`CMP_IDX_BOUND2, 2'b11, b2);
        bus_write(`CMP_IDX_VALUE, 2'b11, v);
        read_check("clamp_flags", `CMP_IDX_FLAGS);
        read_check("clamp_flags", `CMP_IDX_CLAMP);
    endtask

    task automatic clamp_and_flags();
        clamp_case(-16'sd100, 16'sd100, -16'sd200);    // Below
        clamp_case(16'sd100, -16'sd100, 16'sd50);      // Inside, swapped
        clamp_case(-16'sd100, 16'sd100, 16'sd300);     // Above
        clamp_case(16'sd100, -16'sd100, -16'sd150);    // Below, swapped
        clamp_case(-16'sd50, -16'sd10, -16'sd5);       // Above, all negative
        clamp_case(-16'sd10, -16'sd50, -16'sd30);
        clamp_case(16'h8000, 16'h7fff, 16'h0000);      // Full range
        clamp_case(16'sd5, 16'sd5, 16'sd5);            // Empty range, on it
        clamp_case(-16'sd1, 16'sd1, 16'h8000);         // Most negative
    endtask

    task automatic history_shift();
        bus_write(`CMP_IDX_HIST, 2'b11, 16'h0000);
        read_check("history", `CMP_IDX_HIST);
        bus_write(`CMP_IDX_BOUND1, 2'b11, 16'd0);
        bus_write(`CMP_IDX_BOUND2, 2'b11, 16'd100);
        bus_write(`CMP_IDX_VALUE, 2'b11, 16'd50);
        bus_write(`CMP_IDX_VALUE, 2'b11, 16'd200);
        bus_write(`CMP_IDX_VALUE, 2'b11, -16'sd5);
        bus_write(`CMP_IDX_VALUE, 2'b11, 16'd100);
        bus_write(`CMP_IDX_VALUE, 2'b11, 16'd101);
        bus_write(`CMP_IDX_VALUE, 2'b11, 16'd0);
        read_check("history", `CMP_IDX_HIST);
        bus_write(`CMP_IDX_ALIAS2, 2'b11, 16'd500);    // Adds no bit
        read_check("history", `CMP_IDX_HIST);
        bus_write(`CMP_IDX_HIST, 2'b01, 16'h0000);
        read_check("history", `CMP_IDX_HIST);
        // 17 writes so bit 0 is written twice
        for (int i = 0; i < 17; i++) begin
            bus_write(`CMP_IDX_VALUE, 2'b11, (i % 3 == 1) ? 16'd300 : 16'd10);
            if (i == 15)
                read_check("history full", `CMP_IDX_HIST);
        end
        read_check("history wrap", `CMP_IDX_HIST);
    endtask

    task automatic sound_backpressure();
        snd_ready = 1'b0;
        bus_write(`CMP_IDX_SND, 2'b01, 16'h005a);
        @(posedge clk);
        @(negedge clk);                 // Slot loaded by now
        check("sound first irq", 1'b1, snd_irq);
        check("sound first code", 8'h5a, snd.code);
        @(posedge clk);
        #1;
        // Second command must stall while the slot is full
        req_valid = 1'b1;
        req.addr  = `CMP_IDX_SND;
        req.we    = 1'b1;
        req.be    = 2'b01;
        req.wdata = 16'h003c;
        repeat (4) begin
            @(negedge clk);
            check("sound stall req_ready", 1'b0, req_ready);
            check("sound stall irq", 1'b1, snd_irq);
        end
        @(posedge clk);
        #1;
        snd_ready = 1'b1;
        fork
            bus_write(`CMP_IDX_SND, 2'b01, 16'h003c);
            begin
                receive_snd("sound order 1st", 8'h5a);
                receive_snd("sound order 2nd", 8'h3c);
            end
        join
        @(negedge clk);
        check("sound irq cleared", 1'b0, snd_irq);
        @(posedge clk);
        #1;
    endtask

    task automatic random_sweep();
        logic [15:0] v;
        rand_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            bus_write(`CMP_IDX_BOUND1, 2'b11, rand_bits(16));
            bus_write(`CMP_IDX_BOUND2, 2'b11, rand_bits(16));
            v = rand_bits(16);
            // Value goes to either address and only the primary one feeds history
            bus_write(rand_bits(1) ? `CMP_IDX_VALUE : `CMP_IDX_ALIAS2, 2'b11, v);
            read_check("random_sweep", `CMP_IDX_FLAGS);
            read_check("random_sweep", `CMP_IDX_CLAMP);
        end
        read_check("random_sweep", `CMP_IDX_HIST);
        rand_ready = 1'b0;
        resp_ready = 1'b1;
    endtask

    // ------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        snd_ready  = 1'b1;
        rand_ready = 1'b0;
        lfsr_state = 32'hc158_8083;
        m_bound1   = '0;
        m_bound2   = '0;
        m_value    = '0;
        m_hist     = '0;
        m_ptr      = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_decode();
        byte_lanes_aliases();
        clamp_and_flags();
        history_shift();
        sound_backpressure();
        random_sweep();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, a bus handshake never completed");
        $display("STATUS: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

/* rtl/cmp_top.sv */
// Limit comparator top
// Bus port, register file and limiter, with holding slots on the
// read response and on the sound command outputs

`timescale 1ns/10ps
`include "cmp_macros.svh"

module cmp_top import cmp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // CPU requests
    input  logic     req_valid,
    output logic     req_ready,
    input  bus_req_t req,
    // Read responses
    output logic     resp_valid,
    input  logic     resp_ready,
    output rd_resp_t resp,
    // Sound command, valid doubles as the interrupt
    output logic     snd_irq,
    input  logic     snd_ready,
    output snd_cmd_t snd
);

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    logic                          acc_valid;
    reg_acc_t                      acc;
    logic        [`CMP_DATA_W-1:0] reg_rdata;
    logic                          rsp_valid, rsp_ready;
    rd_resp_t                      rsp;
    logic                          cmd_valid, cmd_ready;
    snd_cmd_t                      cmd;
    logic signed [`CMP_DATA_W-1:0] bound1, bound2, value;
    logic        [`CMP_DATA_W-1:0] flags, clamp;

    bus_port u_bus_port (
        .clk, .rst,
        .req_valid, .req_ready, .req,
        .acc_valid, .acc, .rdata(reg_rdata),
        .rsp_valid, .rsp_ready, .rsp,
        .cmd_valid, .cmd_ready, .cmd
    );

    cmp_regs u_regs (
        .clk, .rst,
        .acc_valid, .acc, .rdata(reg_rdata),
        .bound1, .bound2, .value,
        .flags, .clamp
    );

    cmp_limiter u_limiter (
        .clk, .rst,
        .bound1, .bound2, .value,
        .flags, .clamp
    );

    // Read data waits here for the CPU
    hold_slot #(.payload_t(rd_resp_t)) u_resp_slot (
        .clk, .rst,
        .in_valid(rsp_valid),   .in_ready(rsp_ready),  .in_data(rsp),
        .out_valid(resp_valid), .out_ready(resp_ready), .out_data(resp)
    );

    // Pending command holds the sound interrupt
    hold_slot #(.payload_t(snd_cmd_t)) u_snd_slot (
        .clk, .rst,
        .in_valid(cmd_valid), .in_ready(cmd_ready),  .in_data(cmd),
        .out_valid(snd_irq),  .out_ready(snd_ready), .out_data(snd)
    );

endmodule

/* rtl/cmp_limiter.sv */
// Range limiter
// Orders the two bounds as signed numbers, then registers the
// clamped value and the under/over flag word

`timescale 1ns/10ps
`include "cmp_macros.svh"

module cmp_limiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic signed [`CMP_DATA_W-1:0] bound1,
    input  logic signed [`CMP_DATA_W-1:0] bound2,
    input  logic signed [`CMP_DATA_W-1:0] value,
    output logic        [`CMP_DATA_W-1:0] flags,
    output logic        [`CMP_DATA_W-1:0] clamp
);

    logic signed [`CMP_DATA_W-1:0] lo;  // Smaller bound
    logic signed [`CMP_DATA_W-1:0] hi;  // Larger bound

    // Bounds may come in either order
    assign lo = (bound1 < bound2) ? bound1 : bound2;
    assign hi = (bound1 < bound2) ? bound2 : bound1;

    // ------------------------------------------------------------
    // Registered result, one cycle behind the registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clamp <= '0;
            flags <= '0;
        end else if (value < lo) begin
            clamp <= lo;
            flags <= `CMP_FLAG_LOW;
        end else if (value > hi) begin
            clamp <= hi;
            flags <= `CMP_FLAG_HIGH;
        end else begin
            clamp <= value;         // Inside the range
            flags <= '0;
        end
    end

endmodule

/* rtl/cmp_regs.sv */
// Comparator register file
// Bounds and value with byte-lane writes, read decode with the
// alias and open-bus addresses, and the in-range history word

`timescale 1ns/10ps
`include "cmp_macros.svh"

module cmp_regs import cmp_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          acc_valid,
    input  reg_acc_t                      acc,
    output logic        [`CMP_DATA_W-1:0] rdata,
    output logic signed [`CMP_DATA_W-1:0] bound1,
    output logic signed [`CMP_DATA_W-1:0] bound2,
    output logic signed [`CMP_DATA_W-1:0] value,
    input  logic        [`CMP_DATA_W-1:0] flags,
    input  logic        [`CMP_DATA_W-1:0] clamp
);

    localparam int PTR_W = $clog2(`CMP_DATA_W);

    logic [`CMP_DATA_W-1:0] bound1_q;
    logic [`CMP_DATA_W-1:0] bound2_q;
    logic [`CMP_DATA_W-1:0] value_q;
    logic [`CMP_DATA_W-1:0] hist_q;     // One bit per primary value write
    logic [PTR_W-1:0]       ptr_q;      // Next history bit, wraps

    assign bound1 = bound1_q;
    assign bound2 = bound2_q;
    assign value  = value_q;

    // Merge enabled byte lanes over the old contents
    function automatic logic [`CMP_DATA_W-1:0] merge(
        input logic [`CMP_DATA_W-1:0] old,
        input logic [1:0]             be,
        input logic [`CMP_DATA_W-1:0] wdata
    );
        logic [`CMP_DATA_W-1:0] res;
        res = old;
        if (be[1])
            res[15:8] = wdata[15:8];    // Upper byte
        if (be[0])
            res[7:0]  = wdata[7:0];     // Lower byte
        return res;
    endfunction

    // ------------------------------------------------------------
    // Writes
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bound1_q <= '0;
            bound2_q <= '0;
            value_q  <= '0;
            hist_q   <= '0;
            ptr_q    <= '0;
        end else if (acc_valid && acc.we) begin
            case (acc.addr)
                `CMP_IDX_BOUND1: bound1_q <= merge(bound1_q, acc.be, acc.wdata);
                `CMP_IDX_BOUND2: bound2_q <= merge(bound2_q, acc.be, acc.wdata);
                `CMP_IDX_VALUE: begin
                    value_q       <= merge(value_q, acc.be, acc.wdata);
                    // Result of the previous value, flags are settled
                    hist_q[ptr_q] <= (flags == '0);
                    ptr_q         <= ptr_q + 1'b1;
                end
                `CMP_IDX_HIST: begin
                    hist_q <= '0;
                    ptr_q  <= '0;
                end
                // Second value address leaves history alone
                `CMP_IDX_ALIAS2: value_q <= merge(value_q, acc.be, acc.wdata);
                default: ;  // Read-only or unmapped
            endcase
        end
    end

    // ------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------
    always_comb begin
        case (acc.addr)
            `CMP_IDX_BOUND1: rdata = bound1_q;
            `CMP_IDX_BOUND2: rdata = bound2_q;
            `CMP_IDX_VALUE:  rdata = value_q;
            `CMP_IDX_FLAGS:  rdata = flags;
            `CMP_IDX_HIST:   rdata = hist_q;
            `CMP_IDX_ALIAS1: rdata = bound2_q;  // Mirrors of 1 and 2
            `CMP_IDX_ALIAS2: rdata = value_q;
            `CMP_IDX_CLAMP:  rdata = clamp;
            default:         rdata = `CMP_OPEN_BUS;
        endcase
    end

    // Sound writes are split off in the bus port
    a_no_snd_write: assert property (@(posedge clk) disable iff (rst)
        acc_valid && acc.we |-> acc.addr != `CMP_IDX_SND);

endmodule

/* rtl/bus_port.sv */
// CPU bus port
// Takes one request at a time, holds it for a single strobe cycle
// and hands it to the register file, read slot or sound slot

`timescale 1ns/10ps
`include "cmp_macros.svh"

module bus_port import cmp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // CPU request channel
    input  logic                   req_valid,
    output logic                   req_ready,
    input  bus_req_t               req,
    // Register file
    output logic                   acc_valid,
    output reg_acc_t               acc,
    input  logic [`CMP_DATA_W-1:0] rdata,
    // Response slot
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output rd_resp_t               rsp,
    // Sound slot
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output snd_cmd_t               cmd
);

    logic     stb;      // Strobe cycle in progress
    bus_req_t req_q;    // Accepted request
    logic     req_rd;   // Incoming request is a read
    logic     req_snd;  // Incoming request is a sound write
    logic     q_snd;    // Held request is a sound write

    // ------------------------------------------------------------
    // Accept side
    // ------------------------------------------------------------
    assign req_rd  = !req.we;
    assign req_snd = req.we && (req.addr == `CMP_IDX_SND);

    // Busy in strobe, or the outlet this request needs is blocked
    assign req_ready = !stb
                     && !(req_rd  && !rsp_ready)
                     && !(req_snd && !cmd_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            stb <= 1'b0;
        else
            stb <= req_valid && req_ready;  // One cycle only
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            req_q <= req;
    end

    // ------------------------------------------------------------
    // Strobe side, exactly one outlet fires
    // ------------------------------------------------------------
    assign q_snd = req_q.we && (req_q.addr == `CMP_IDX_SND);

    assign acc       = reg_acc_t'{addr: req_q.addr, we: req_q.we,
                                  be: req_q.be, wdata: req_q.wdata};
    assign acc_valid = stb && req_q.we && !q_snd;   // Register writes

    assign rsp_valid = stb && !req_q.we;            // Read capture
    assign rsp       = rd_resp_t'{rdata: rdata};    // Decode address is live

    assign cmd_valid = stb && q_snd;
    assign cmd       = snd_cmd_t'{code: req_q.wdata[`CMP_SND_W-1:0]};

    // Accepts are at least two cycles apart
    a_acc_single: assert property (@(posedge clk) disable iff (rst)
        acc_valid |=> !acc_valid);

endmodule

/* rtl/hold_slot.sv */
// Single entry holding register
// Valid/ready on both sides, payload type set per instance

`timescale 1ns/10ps

module hold_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;     // Slot occupied
    payload_t data_q;   // Stored item

    // Free now, or emptied on this same edge
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;           // Load wins over drain
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    // Payload only, no reset
    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

    // Held item must not move while the consumer stalls
    a_stable_out: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

/* rtl/cmp_pkg.sv */
// Limit comparator types
// Packed structs for the CPU bus, read data, sound commands
// and the internal register access strobe

`include "cmp_macros.svh"

package cmp_pkg;

    // ------------------------------------------------------------
    // CPU side
    // ------------------------------------------------------------

    // One request on the bus port
    typedef struct packed {
        logic [`CMP_ADDR_W-1:0] addr;   // Word address
        logic                   we;     // 1 for write
        logic [1:0]             be;     // Bit 1 is upper byte
        logic [`CMP_DATA_W-1:0] wdata;
    } bus_req_t;

    // Read result back to the CPU
    typedef struct packed {
        logic [`CMP_DATA_W-1:0] rdata;
    } rd_resp_t;

    // ------------------------------------------------------------
    // Sound side
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`CMP_SND_W-1:0] code;    // Command byte for sound CPU
    } snd_cmd_t;

    // ------------------------------------------------------------
    // Internal
    // ------------------------------------------------------------

    // Access strobed from the bus port into the register file
    typedef struct packed {
        logic [`CMP_ADDR_W-1:0] addr;
        logic                   we;
        logic [1:0]             be;
        logic [`CMP_DATA_W-1:0] wdata;
    } reg_acc_t;

endpackage

/* include/cmp_macros.svh */
// Limit comparator constants
// Widths, register map and fixed read values shared by the RTL

`ifndef CMP_MACROS_SVH
`define CMP_MACROS_SVH

// ------------------------------------------------------------
// Widths
// ------------------------------------------------------------
`define CMP_ADDR_W      4       // Word address into the chip
`define CMP_DATA_W      16      // Register width
`define CMP_SND_W       8       // Sound command byte

// ------------------------------------------------------------
// Fixed values
// ------------------------------------------------------------
`define CMP_FLAG_LOW    16'h8000 // Value under the range
`define CMP_FLAG_HIGH   16'h4000 // Value over the range
`define CMP_OPEN_BUS    16'hffff // Nothing mapped here

// Register map
`define CMP_IDX_BOUND1  0
`define CMP_IDX_BOUND2  1
`define CMP_IDX_VALUE   2       // Primary value address, feeds history
`define CMP_IDX_FLAGS   3
`define CMP_IDX_HIST    4       // Write clears history and pointer
`define CMP_IDX_ALIAS1  5       // Reads bound 2
`define CMP_IDX_ALIAS2  6       // Reads and writes value, no history
`define CMP_IDX_CLAMP   7
`define CMP_IDX_SND     15      // Sound command latch

`endif
